// ==== Bender.yml ====
package:
  name: axis_array_packet_generator

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axis_gen_pkg.sv
      - verilog/axis_packet_generator.sv
      - verilog/axis_packet_mux.sv
      - verilog/axis_array_packet_generator.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/axis_array_packet_generator_tb.sv

// ==== verification/axis_array_packet_generator_tb.sv ====
////////////////////////////////////////////////////////////
// Random-traffic testbench for the multi-port packet source.
// Per-port byte model checks every output beat and counter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "axis_gen_params.svh"

module axis_array_packet_generator_tb;

    import axis_gen_pkg::*;

    localparam int NUM_PKTS  = 12;
    localparam int MEM_DEPTH = NUM_PKTS * MTU_BYTES;
    localparam int TIMEOUT_CYCLES =
        `AXIS_NUM_PORTS * NUM_PKTS * (`AXIS_MTU_BYTES / `AXIS_DATA_BYTES + 20) * 3;

    logic                 clk_ifc = 1'b0;
    logic                 rst_n;
    logic [NUM_PORTS-1:0] send_req;
    blen_t                packet_blen [NUM_PORTS];
    pkt_buf_t             packet_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] busy;
    logic                 out_valid;
    beat_t                out_beat;
    logic                 out_ready;
    pkt_count_t           pkt_count [NUM_PORTS];

    integer seed = 32'hb21b;
    int     errors = 0;
    int     checks = 0;
    int     cycle_count = 0;
    int     ports_done = 0;

    // Per-port expected bytes and packet lengths
    logic [7:0] exp_mem [NUM_PORTS][MEM_DEPTH];
    int         exp_len [NUM_PORTS][NUM_PKTS];
    int         byte_head [NUM_PORTS];
    int         byte_tail [NUM_PORTS];
    int         len_head [NUM_PORTS];
    int         len_tail [NUM_PORTS];
    int         pkt_off [NUM_PORTS];
    logic       idle_pending [NUM_PORTS];

    // Open-packet and stall tracking on the output
    logic       open_valid = 1'b0;
    int         open_port = 0;
    // Port 0 wins first after reset
    int         last_port = NUM_PORTS - 1;
    logic       hold_pending = 1'b0;
    beat_t      held_beat;

    axis_array_packet_generator UUT (
        .clk_ifc     (clk_ifc),
        .rst_n       (rst_n),
        .send_req    (send_req),
        .packet_blen (packet_blen),
        .packet_data (packet_data),
        .busy        (busy),
        .out_valid   (out_valid),
        .out_beat    (out_beat),
        .out_ready   (out_ready),
        .pkt_count   (pkt_count)
    );

    always #5 clk_ifc = ~clk_ifc;

    ////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_beat(input string name, input beat_t act, input beat_t exp);
        checks++;
        if (act.data !== exp.data) begin
            errors++;
            $display("MISMATCH %s.data got %h expected %h", name, act.data, exp.data);
        end
        if (act.keep !== exp.keep) begin
            errors++;
            $display("MISMATCH %s.keep got %h expected %h", name, act.keep, exp.keep);
        end
        if (act.last !== exp.last) begin
            errors++;
            $display("MISMATCH %s.last got %h expected %h", name, act.last, exp.last);
        end
        if (act.dest !== exp.dest) begin
            errors++;
            $display("MISMATCH %s.dest got %h expected %h", name, act.dest, exp.dest);
        end
    endtask

    task automatic check_count(input string name, input pkt_count_t act, input pkt_count_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, act, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    ////////////////////////////////////////////////////////////
    // Model

    task automatic record_packet(input int p, input pkt_buf_t d, input int len);
        for (int b = 0; b < len; b++) begin
            exp_mem[p][byte_tail[p] + b] = d[b*8 +: 8];
        end
        byte_tail[p] += len;
        exp_len[p][len_tail[p]] = len;
        len_tail[p]++;
    endtask

    function automatic logic queues_empty();
        queues_empty = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (len_head[p] != len_tail[p]) begin
                queues_empty = 1'b0;
            end
        end
    endfunction

    // Round-robin choice among presenting ports, starting after the previous winner
    function automatic int next_grant(input int prev);
        int q;
        next_grant = -1;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            q = (prev + k) % NUM_PORTS;
            if (next_grant < 0 && busy[q]) begin
                next_grant = q;
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // One requester process per port

    for (genvar gp = 0; gp < NUM_PORTS; gp++) begin : g_drv
        initial begin : drive
            integer   pseed;
            pkt_buf_t pdata;
            int       len;
            int       gap;
            wait (rst_n === 1'b1);
            pseed = seed + gp * 32'h1013;
            for (int n = 0; n < NUM_PKTS; n++) begin
                @(negedge clk_ifc);
                gap = {$random(pseed)} % 6;
                repeat (gap) @(negedge clk_ifc);
                len = 1 + {$random(pseed)} % MTU_BYTES;
                for (int b = 0; b < MTU_BYTES; b++) begin
                    pdata[b*8 +: 8] = {$random(pseed)} % 256;
                end
                packet_data[gp] = pdata;
                packet_blen[gp] = blen_t'(len);
                send_req[gp]    = 1'b1;
                if (!busy[gp]) begin
                    record_packet(gp, pdata, len);
                end
                @(negedge clk_ifc);
                check_flag("busy after request", busy[gp], 1'b1);
                send_req[gp] = 1'b0;
                // Stray request with fresh data while busy
                if ({$random(pseed)} % 2) begin
                    packet_data[gp] = ~pdata;
                    packet_blen[gp] = blen_t'(1 + {$random(pseed)} % MTU_BYTES);
                    send_req[gp]    = 1'b1;
                    if (!busy[gp]) begin
                        record_packet(gp, ~pdata, int'(packet_blen[gp]));
                    end
                    @(negedge clk_ifc);
                    send_req[gp] = 1'b0;
                end
                while (busy[gp]) @(negedge clk_ifc);
            end
            ports_done++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output monitor

    always @(posedge clk_ifc) begin : monitor
        beat_t exp;
        int    p;
        int    rem;
        int    n;
        if (rst_n) begin
            if (hold_pending) begin
                check_flag("out_valid held", out_valid, 1'b1);
                check_beat("out_beat held", out_beat, held_beat);
            end
            hold_pending = out_valid && !out_ready;
            held_beat    = out_beat;
            for (int q = 0; q < NUM_PORTS; q++) begin
                if (idle_pending[q]) begin
                    check_flag("busy after last beat", busy[q], 1'b0);
                    idle_pending[q] = 1'b0;
                end
            end
            // A packet opens when its first beat is presented, stalled or not
            if (out_valid && !open_valid) begin
                open_port  = next_grant(last_port);
                open_valid = (open_port >= 0);
                if (!open_valid) begin
                    report_error("out_valid high while no port is busy");
                end
            end
            if (out_valid && out_ready && open_valid) begin
                p = open_port;
                check_flag("busy during transfer", busy[p], 1'b1);
                if (len_head[p] == len_tail[p]) begin
                    report_error($sformatf("beat for port %0d with no pending packet", p));
                end else begin
                    rem = exp_len[p][len_head[p]] - pkt_off[p];
                    n   = (rem < DATA_BYTES) ? rem : DATA_BYTES;
                    // Unkept lanes are not compared
                    exp      = out_beat;
                    exp.dest = port_id_t'(p);
                    exp.last = (rem <= DATA_BYTES);
                    for (int j = 0; j < DATA_BYTES; j++) begin
                        exp.keep[j] = (j < n);
                        if (j < n) begin
                            exp.data[j] = exp_mem[p][byte_head[p] + j];
                        end
                    end
                    check_beat("out_beat", out_beat, exp);
                    byte_head[p] += n;
                    pkt_off[p]   += n;
                    if (exp.last) begin
                        len_head[p]++;
                        pkt_off[p]      = 0;
                        open_valid      = 1'b0;
                        last_port       = p;
                        idle_pending[p] = 1'b1;
                    end
                end
            end
        end
    end

    always @(posedge clk_ifc) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin : main
        int base;
        int total;
        rst_n     = 1'b0;
        send_req  = '0;
        out_ready = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            packet_blen[p]  = '0;
            packet_data[p]  = '0;
            byte_head[p]    = 0;
            byte_tail[p]    = 0;
            len_head[p]     = 0;
            len_tail[p]     = 0;
            pkt_off[p]      = 0;
            idle_pending[p] = 1'b0;
        end
        repeat (2) @(negedge clk_ifc);
        rst_n = 1'b1;

        base = errors;
        check_flag("out_valid", out_valid, 1'b0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_flag("busy", busy[p], 1'b0);
            check_count("pkt_count", pkt_count[p], '0);
        end
        $display("test reset state: %s", (errors == base) ? "pass" : "FAIL");

        // Random back-pressure until all traffic has drained
        base = errors;
        while (ports_done < NUM_PORTS || !queues_empty()) begin
            @(negedge clk_ifc);
            if ({$random(seed)} % 100 < 30) begin
                out_ready = ~out_ready;
            end
        end
        total = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            total += len_tail[p];
        end
        $display("test random traffic: %0d packets, %s", total,
                 (errors == base) ? "pass" : "FAIL");

        base = errors;
        out_ready = 1'b1;
        repeat (2) @(negedge clk_ifc);
        check_flag("out_valid", out_valid, 1'b0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_flag("busy", busy[p], 1'b0);
            if (byte_head[p] != byte_tail[p]) begin
                report_error($sformatf("port %0d has %0d bytes never sent", p,
                                       byte_tail[p] - byte_head[p]));
            end
        end
        $display("test drain: %s", (errors == base) ? "pass" : "FAIL");

        base = errors;
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_count("pkt_count", pkt_count[p], pkt_count_t'(len_tail[p]));
        end
        $display("test packet counters: %s", (errors == base) ? "pass" : "FAIL");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/axis_gen_pkg.sv
verilog/axis_packet_generator.sv
verilog/axis_packet_mux.sv
verilog/axis_array_packet_generator.sv
verification/axis_array_packet_generator_tb.sv

// ==== verilog/axis_array_packet_generator.sv ====
////////////////////////////////////////////////////////////
// Top of the packet source. One generator per requester
// port, all merged onto a single output stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axis_array_packet_generator (
    input  logic                                clk_ifc,
    input  logic                                rst_n,
    input  logic [axis_gen_pkg::NUM_PORTS-1:0]  send_req,
    input  axis_gen_pkg::blen_t                 packet_blen [axis_gen_pkg::NUM_PORTS],
    input  axis_gen_pkg::pkt_buf_t              packet_data [axis_gen_pkg::NUM_PORTS],
    output logic [axis_gen_pkg::NUM_PORTS-1:0]  busy,
    output logic                                out_valid,
    output axis_gen_pkg::beat_t                 out_beat,
    input  logic                                out_ready,
    output axis_gen_pkg::pkt_count_t            pkt_count [axis_gen_pkg::NUM_PORTS]
);

    import axis_gen_pkg::*;

    // Per-port streams into the merge stage
    logic [NUM_PORTS-1:0] gen_valid;
    logic [NUM_PORTS-1:0] gen_ready;
    beat_t                gen_beat [NUM_PORTS];

    ////////////////////////////////////////////////////////////
    // Port generators

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        axis_packet_generator u_gen (
            .clk_ifc     (clk_ifc),
            .rst_n       (rst_n),
            .send_req    (send_req[p]),
            .packet_blen (packet_blen[p]),
            .packet_data (packet_data[p]),
            .busy        (busy[p]),
            .gen_valid   (gen_valid[p]),
            .gen_beat    (gen_beat[p]),
            .gen_ready   (gen_ready[p])
        );
    end

    ////////////////////////////////////////////////////////////
    // Output merge

    axis_packet_mux u_mux (
        .clk_ifc   (clk_ifc),
        .rst_n     (rst_n),
        .gen_valid (gen_valid),
        .gen_beat  (gen_beat),
        .gen_ready (gen_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready),
        .pkt_count (pkt_count)
    );

endmodule

// ==== verilog/axis_gen_params.svh ====
////////////////////////////////////////////////////////////
// Build-time sizes for the packet source.
// Included by the type package and by the testbench
////////////////////////////////////////////////////////////

`ifndef AXIS_GEN_PARAMS_SVH
`define AXIS_GEN_PARAMS_SVH

// Number of requester ports merged onto the output stream
`define AXIS_NUM_PORTS 4

// Bytes carried by one stream beat
`define AXIS_DATA_BYTES 8

// Largest packet a requester may load, in bytes
`define AXIS_MTU_BYTES 256

`endif

// ==== verilog/axis_gen_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types for the multi-port packet source.
// Import inside module bodies, scope in port lists
////////////////////////////////////////////////////////////

`include "axis_gen_params.svh"

package axis_gen_pkg;

    localparam int NUM_PORTS  = `AXIS_NUM_PORTS;
    localparam int DATA_BYTES = `AXIS_DATA_BYTES;
    localparam int MTU_BYTES  = `AXIS_MTU_BYTES;

    localparam int PORT_W  = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    // Must hold MTU_BYTES itself, not just MTU_BYTES-1
    localparam int BLEN_W  = $clog2(MTU_BYTES + 1);
    localparam int COUNT_W = 16;

    ////////////////////////////////////////////////////////////
    // Scalar types

    typedef logic [PORT_W-1:0]      port_id_t;
    typedef logic [BLEN_W-1:0]      blen_t;
    typedef logic [COUNT_W-1:0]     pkt_count_t;

    // Byte i at bits [i*8 +: 8]
    typedef logic [MTU_BYTES*8-1:0] pkt_buf_t;

    ////////////////////////////////////////////////////////////
    // Stream beat

    typedef struct packed {
        logic [DATA_BYTES-1:0][7:0] data;
        logic [DATA_BYTES-1:0]      keep;
        logic                       last;
        port_id_t                   dest;
    } beat_t;

endpackage

// ==== verilog/axis_packet_generator.sv ====
////////////////////////////////////////////////////////////
// Single requester port. Takes one buffered packet per
// request and emits it as keep-masked stream beats
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axis_packet_generator (
    input  logic                   clk_ifc,
    input  logic                   rst_n,
    input  logic                   send_req,
    input  axis_gen_pkg::blen_t    packet_blen,
    input  axis_gen_pkg::pkt_buf_t packet_data,
    output logic                   busy,
    output logic                   gen_valid,
    output axis_gen_pkg::beat_t    gen_beat,
    input  logic                   gen_ready
);

    import axis_gen_pkg::*;

    ////////////////////////////////////////////////////////////
    // Local sizes

    localparam int BEAT_BITS = DATA_BYTES * 8;
    localparam int MAX_BEATS = (MTU_BYTES + DATA_BYTES - 1) / DATA_BYTES;
    localparam int IDX_W     = (MAX_BEATS > 1) ? $clog2(MAX_BEATS) : 1;
    // Buffer rounded up to whole beats
    localparam int PAD_W     = MAX_BEATS * BEAT_BITS;

    typedef logic [IDX_W-1:0] beat_idx_t;

    ////////////////////////////////////////////////////////////
    // Declarations

    // Packet copy, loaded on acceptance
    pkt_buf_t              buf_q;
    logic [PAD_W-1:0]      buf_pad;

    logic                  active_q;
    beat_idx_t             beat_idx_q;
    // Bytes not yet handed downstream, counting the current beat
    blen_t                 rem_q;

    logic                  accept;
    logic                  xfer;
    logic                  last_beat;
    logic [DATA_BYTES-1:0] keep;

    ////////////////////////////////////////////////////////////
    // Handshake decode

    // A request is only seen while idle
    assign accept = send_req && !active_q;
    assign xfer   = gen_valid && gen_ready;

    // Valid and busy share one flag so busy drops right after the last beat
    assign busy      = active_q;
    assign gen_valid = active_q;

    // Final beat once at most one beat's worth of bytes remains
    assign last_beat = (rem_q <= blen_t'(DATA_BYTES));

    ////////////////////////////////////////////////////////////
    // Beat formation

    assign buf_pad = PAD_W'(buf_q);

    // Lanes below the remaining count hold packet bytes
    always_comb begin
        for (int j = 0; j < DATA_BYTES; j++) begin
            keep[j] = (j < int'(rem_q));
        end
    end

    always_comb begin
        gen_beat      = '0;
        gen_beat.data = buf_pad[beat_idx_q*BEAT_BITS +: BEAT_BITS];
        gen_beat.keep = keep;
        gen_beat.last = last_beat;
        // Port number is filled in by the merge stage
        gen_beat.dest = '0;
    end

    ////////////////////////////////////////////////////////////
    // Control state

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            active_q   <= 1'b0;
            beat_idx_q <= '0;
            rem_q      <= '0;
        end else if (accept) begin
            active_q   <= 1'b1;
            beat_idx_q <= '0;
            rem_q      <= packet_blen;
        end else if (xfer) begin
            if (last_beat) begin
                active_q <= 1'b0;
            end else begin
                beat_idx_q <= beat_idx_q + 1'b1;
                rem_q      <= rem_q - blen_t'(DATA_BYTES);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Payload capture

    // Requester is free to reuse its buffer once busy is seen
    always_ff @(posedge clk_ifc) begin
        if (accept) begin
            buf_q <= packet_data;
        end
    end

endmodule

// ==== verilog/axis_packet_mux.sv ====
////////////////////////////////////////////////////////////
// Packet-level round-robin merge of all ports onto one
// stream, with dest set to the source port and sent counts
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axis_packet_mux (
    input  logic                                clk_ifc,
    input  logic                                rst_n,
    input  logic [axis_gen_pkg::NUM_PORTS-1:0]  gen_valid,
    input  axis_gen_pkg::beat_t                 gen_beat [axis_gen_pkg::NUM_PORTS],
    output logic [axis_gen_pkg::NUM_PORTS-1:0]  gen_ready,
    output logic                                out_valid,
    output axis_gen_pkg::beat_t                 out_beat,
    input  logic                                out_ready,
    output axis_gen_pkg::pkt_count_t            pkt_count [axis_gen_pkg::NUM_PORTS]
);

    import axis_gen_pkg::*;

    ////////////////////////////////////////////////////////////
    // Declarations

    // Port that won the previous packet
    port_id_t rr_ptr_q;
    port_id_t grant_q;
    logic     locked_q;

    port_id_t pick;
    logic     pick_valid;
    port_id_t sel;
    logic     out_xfer;
    logic     out_done;

    ////////////////////////////////////////////////////////////
    // Arbitration

    // First valid port after the previous winner
    always_comb begin
        int idx;
        pick       = rr_ptr_q;
        pick_valid = 1'b0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = (int'(rr_ptr_q) + k) % NUM_PORTS;
            if (!pick_valid && gen_valid[idx]) begin
                pick       = port_id_t'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    // Held grant wins until the packet ends
    assign sel = locked_q ? grant_q : pick;

    ////////////////////////////////////////////////////////////
    // Datapath steering

    assign out_valid = gen_valid[sel];

    always_comb begin
        out_beat      = gen_beat[sel];
        out_beat.dest = sel;
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            gen_ready[p] = out_ready && (sel == port_id_t'(p));
        end
    end

    assign out_xfer = out_valid && out_ready;
    assign out_done = out_xfer && out_beat.last;

    ////////////////////////////////////////////////////////////
    // Grant lock and pointer

    // Lock on any presented beat so a stalled beat never switches source
    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            rr_ptr_q <= port_id_t'(NUM_PORTS - 1);
            grant_q  <= '0;
            locked_q <= 1'b0;
        end else if (out_done) begin
            locked_q <= 1'b0;
            rr_ptr_q <= sel;
        end else if (out_valid) begin
            locked_q <= 1'b1;
            grant_q  <= sel;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sent-packet counters

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            pkt_count <= '{default: '0};
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (out_done && (sel == port_id_t'(p))) begin
                    pkt_count[p] <= pkt_count[p] + 1'b1;
                end
            end
        end
    end

endmodule
